/* vlog.f */
+incdir+source
source/alu_exec_pkg.sv
source/alu_ctrl_decoder.sv
source/phy_regfile.sv
source/alu_pipe.sv
source/alu_exec_top.sv
tb/alu_exec_assertions.sv
tb/alu_exec_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = alu_exec_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run fails unless the pass line appears in the output.
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ_DIR)

/* tb/alu_exec_tb.sv */
`include "alu_exec_params.svh"

module alu_exec_tb
  import alu_exec_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_CYCLES = 2000;

  typedef struct packed {
    logic [31:0]               due;
    logic                      done_valid;
    logic                      wb_valid;
    logic [`RNID_W-1:0]        rnid;
    logic [`XLEN-1:0]          data;
    logic [`RV_ENTRY_SIZE-1:0] index_oh;
  } expect_t;

  typedef struct packed {
    logic [31:0]        due;
    logic               valid;
    logic [`RNID_W-1:0] rnid;
  } early_exp_t;

  logic                      i_clk;
  logic                      i_reset_n;
  issue_t                    i_issue;
  logic [`RV_ENTRY_SIZE-1:0] i_issue_index_oh;
  phy_wr_t                   i_ext_phy_wr;
  early_wr_t                 o_early_wr;
  phy_wr_t                   o_phy_wr;
  done_t                     o_done;

  logic [`XLEN-1:0] shadow [`PHY_REGS]; // GPR reference values.
  expect_t          wb_q [$];
  early_exp_t       early_q [$];
  logic [31:0]      cyc = '0;
  integer           seed = 27;
  int               errors = 0;
  int               n_tests = 0;
  int               n_failed = 0;

  alu_exec_top alu_exec_top_inst (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_issue          (i_issue),
    .i_issue_index_oh (i_issue_index_oh),
    .i_ext_phy_wr     (i_ext_phy_wr),
    .o_early_wr       (o_early_wr),
    .o_phy_wr         (o_phy_wr),
    .o_done           (o_done)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cyc <= cyc + 32'd1;
    if (cyc >= MAX_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  // Outputs are stable at the falling edge.
  always @(negedge i_clk) begin
    if (i_reset_n) begin
      check_outputs();
    end
  end

  function automatic logic [31:0] r_type_inst(input logic [6:0] f7, input logic [6:0] opc);
    return {f7, 10'h000, 3'b000, 5'h00, opc};
  endfunction

  function automatic logic [31:0] i_type_inst(input logic [11:0] imm, input logic [2:0] f3,
                                              input logic [6:0] opc);
    return {imm, 5'h00, f3, 5'h00, opc};
  endfunction

  function automatic logic [31:0] u_type_inst(input logic [19:0] imm, input logic [6:0] opc);
    return {imm, 5'h00, opc};
  endfunction

  // RV64 semantics of the supported subset. Anything else gives zero.
  function automatic logic [63:0] model_result(input logic [31:0] inst, input logic [63:0] pc,
                                               input logic [63:0] a, input logic [63:0] b);
    logic [63:0] uimm;
    logic [63:0] iimm;
    logic [31:0] w;
    uimm = {{32{inst[31]}}, inst[31:12], 12'h000};
    iimm = {{52{inst[31]}}, inst[31:20]};
    case (inst[6:0])
      7'h37: return uimm;
      7'h17: return pc + uimm;
      7'h33: begin
        if (inst[14:12] == 3'b000 && inst[31:25] == 7'h00) return a + b;
        if (inst[14:12] == 3'b000 && inst[31:25] == 7'h20) return a - b;
      end
      7'h13: if (inst[14:12] == 3'b000) return a + iimm;
      7'h3b: begin
        if (inst[14:12] == 3'b000 && inst[31:25] == 7'h00) begin
          w = a[31:0] + b[31:0];
          return {{32{w[31]}}, w};
        end
      end
      7'h1b: begin
        if (inst[14:12] == 3'b000) begin
          w = a[31:0] + iimm[31:0];
          return {{32{w[31]}}, w};
        end
      end
      default: return 64'h0;
    endcase
    return 64'h0;
  endfunction

  task automatic tick();
    @(posedge i_clk);
    #2;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) tick();
  endtask

  task automatic compare_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_outputs();
    expect_t    e;
    early_exp_t w;
    e = '0;
    w = '0;
    if (wb_q.size() > 0 && wb_q[0].due == cyc) e = wb_q.pop_front();
    if (early_q.size() > 0 && early_q[0].due == cyc) w = early_q.pop_front();
    compare_value("o_early_wr.valid", 64'(w.valid), 64'(o_early_wr.valid));
    if (w.valid) begin
      compare_value("o_early_wr.rd_rnid", 64'(w.rnid), 64'(o_early_wr.rd_rnid));
      compare_value("o_early_wr.rd_type", 64'(GPR), 64'(o_early_wr.rd_type));
    end
    compare_value("o_done.valid", 64'(e.done_valid), 64'(o_done.valid));
    if (e.done_valid) begin
      compare_value("o_done.index_oh", 64'(e.index_oh), 64'(o_done.index_oh));
    end
    compare_value("o_phy_wr.valid", 64'(e.wb_valid), 64'(o_phy_wr.valid));
    if (e.wb_valid) begin
      compare_value("o_phy_wr.rd_rnid", 64'(e.rnid), 64'(o_phy_wr.rd_rnid));
      compare_value("o_phy_wr.rd_type", 64'(GPR), 64'(o_phy_wr.rd_type));
      compare_value("o_phy_wr.rd_data", e.data, o_phy_wr.rd_data);
    end
  endtask

  task automatic drive_ext(input reg_type_e t, input logic [5:0] id, input logic [63:0] data);
    i_ext_phy_wr = '{valid: 1'b1, rd_type: t, rd_rnid: id, rd_data: data};
    if (t == GPR) shadow[id] = data;
    tick();
    i_ext_phy_wr = '0;
  endtask

  task automatic issue_inst(input logic vld, input logic [31:0] inst, input logic [63:0] pc,
                            input logic rd_v, input logic [5:0] rd, input logic [5:0] rs1,
                            input logic [5:0] rs2);
    logic        rs1_v;
    logic        rs2_v;
    logic [63:0] res;
    logic [31:0] r;
    logic [7:0]  idx;
    expect_t     e;
    early_exp_t  w;
    rs1_v = !(inst[6:0] == 7'h37 || inst[6:0] == 7'h17); // No sources for LUI and AUIPC.
    rs2_v = (inst[6:0] == 7'h33 || inst[6:0] == 7'h3b);
    r = $random(seed);
    idx = 8'b1 << r[2:0];
    res = model_result(inst, pc, rs1_v ? shadow[rs1] : 64'h0, rs2_v ? shadow[rs2] : 64'h0);
    i_issue = '0;
    i_issue.valid = vld;
    i_issue.inst = inst;
    i_issue.pc_addr = pc;
    i_issue.rd_valid = rd_v;
    i_issue.rd_rnid = rd;
    i_issue.rs1_valid = rs1_v;
    i_issue.rs1_rnid = rs1;
    i_issue.rs2_valid = rs2_v;
    i_issue.rs2_rnid = rs2;
    i_issue_index_oh = idx;
    if (vld) begin
      e = '{due: cyc + 32'd3, done_valid: 1'b1, wb_valid: rd_v, rnid: rd, data: res,
            index_oh: idx};
      wb_q.push_back(e);
      if (rd_v) begin
        w = '{due: cyc + 32'd1, valid: 1'b1, rnid: rd};
        early_q.push_back(w);
        shadow[rd] = res;
      end
    end
    tick();
    i_issue = '0;
    i_issue_index_oh = '0;
  endtask

  task automatic report_test(input string name, input int err_start);
    while (wb_q.size() > 0 || early_q.size() > 0) tick();
    n_tests++;
    if (errors != err_start) n_failed++;
    $display("test %s done, %0d errors", name, errors - err_start);
  endtask

  task automatic register_ops();
    int          err_start;
    logic [31:0] r;
    logic [31:0] s;
    err_start = errors;
    for (int i = 1; i <= 8; i++) begin
      r = $random(seed);
      s = $random(seed);
      drive_ext(GPR, 6'(i), {r, s});
    end
    for (int k = 0; k < 4; k++) begin
      r = $random(seed);
      issue_inst(1'b1, r_type_inst(7'h00, 7'h33), 64'h0, 1'b1, 6'd9 + {3'b0, r[8:6]},
                 6'd1 + {3'b0, r[2:0]}, 6'd1 + {3'b0, r[5:3]});
      wait_cycles(3);
      issue_inst(1'b1, r_type_inst(7'h20, 7'h33), 64'h0, 1'b1, 6'd9 + {3'b0, r[11:9]},
                 6'd1 + {3'b0, r[5:3]}, 6'd1 + {3'b0, r[2:0]});
      wait_cycles(3);
      issue_inst(1'b1, i_type_inst(r[31:20], 3'b000, 7'h13), 64'h0, 1'b1, 6'd9 + {3'b0, r[14:12]},
                 6'd1 + {3'b0, r[17:15]}, 6'd0);
      wait_cycles(3);
    end
    report_test("register_ops", err_start);
  endtask

  task automatic upper_imm_ops();
    int          err_start;
    logic [63:0] pc;
    err_start = errors;
    pc = {$random(seed), $random(seed)};
    issue_inst(1'b1, u_type_inst(20'h80001, 7'h37), 64'h0, 1'b1, 6'd20, 6'd0, 6'd0);
    issue_inst(1'b1, u_type_inst(20'h12345, 7'h37), 64'h0, 1'b1, 6'd21, 6'd0, 6'd0);
    issue_inst(1'b1, u_type_inst(20'hfffff, 7'h17), pc, 1'b1, 6'd22, 6'd0, 6'd0);
    issue_inst(1'b1, u_type_inst(20'h7ffff, 7'h17), pc + 64'd4, 1'b1, 6'd23, 6'd0, 6'd0);
    report_test("upper_imm_ops", err_start);
  endtask

  task automatic word_ops();
    int          err_start;
    logic [31:0] r;
    err_start = errors;
    r = $random(seed);
    drive_ext(GPR, 6'd24, {r, 32'h7fffffff});
    r = $random(seed);
    drive_ext(GPR, 6'd25, {r, 32'h00000001});
    r = $random(seed);
    drive_ext(GPR, 6'd26, {r, 32'h80000000});
    issue_inst(1'b1, r_type_inst(7'h00, 7'h3b), 64'h0, 1'b1, 6'd27, 6'd24, 6'd25);
    issue_inst(1'b1, i_type_inst(12'h7ff, 3'b000, 7'h1b), 64'h0, 1'b1, 6'd28, 6'd24, 6'd0);
    issue_inst(1'b1, i_type_inst(12'hfff, 3'b000, 7'h1b), 64'h0, 1'b1, 6'd29, 6'd26, 6'd0);
    issue_inst(1'b1, r_type_inst(7'h00, 7'h3b), 64'h0, 1'b1, 6'd27, 6'd26, 6'd26);
    report_test("word_ops", err_start);
  endtask

  task automatic dependency_chains();
    int          err_start;
    logic [31:0] r;
    err_start = errors;
    for (int d = 1; d <= 3; d++) begin
      drive_ext(GPR, 6'd30, {$random(seed), $random(seed)});
      r = $random(seed);
      issue_inst(1'b1, i_type_inst(r[11:0], 3'b000, 7'h13), 64'h0, 1'b1, 6'd31, 6'd30, 6'd0);
      repeat (d - 1) issue_inst(1'b1, i_type_inst(12'h001, 3'b000, 7'h13), 64'h0, 1'b1,
                                6'd40, 6'd41, 6'd0); // Unrelated filler.
      issue_inst(1'b1, r_type_inst(7'h00, 7'h33), 64'h0, 1'b1, 6'd32, 6'd31, 6'd31);
      repeat (d - 1) issue_inst(1'b1, i_type_inst(12'h001, 3'b000, 7'h13), 64'h0, 1'b1,
                                6'd40, 6'd41, 6'd0);
      issue_inst(1'b1, r_type_inst(7'h20, 7'h33), 64'h0, 1'b1, 6'd33, 6'd32, 6'd31);
      issue_inst(1'b1, r_type_inst(7'h00, 7'h3b), 64'h0, 1'b1, 6'd34, 6'd33, 6'd32);
      wait_cycles(4);
    end
    report_test("dependency_chains", err_start);
  endtask

  task automatic ext_forwarding();
    int          err_start;
    logic [63:0] v;
    err_start = errors;
    drive_ext(GPR, 6'd50, {$random(seed), $random(seed)});
    wait_cycles(1);
    v = {$random(seed), $random(seed)};
    shadow[50] = v; // Lands in the consumer's EX2.
    issue_inst(1'b1, r_type_inst(7'h00, 7'h33), 64'h0, 1'b1, 6'd51, 6'd50, 6'd50);
    tick();
    drive_ext(GPR, 6'd50, v);
    wait_cycles(3);
    issue_inst(1'b1, r_type_inst(7'h00, 7'h33), 64'h0, 1'b1, 6'd52, 6'd50, 6'd50);
    tick();
    drive_ext(FPR, 6'd50, {$random(seed), $random(seed)});
    wait_cycles(3);
    issue_inst(1'b1, r_type_inst(7'h00, 7'h33), 64'h0, 1'b1, 6'd53, 6'd50, 6'd50);
    report_test("ext_forwarding", err_start);
  endtask

  task automatic completion_rules();
    int err_start;
    err_start = errors;
    issue_inst(1'b1, r_type_inst(7'h00, 7'h33), 64'h0, 1'b0, 6'd60, 6'd1, 6'd2);
    issue_inst(1'b1, i_type_inst(12'h005, 3'b001, 7'h13), 64'h0, 1'b1, 6'd61, 6'd1, 6'd0);
    issue_inst(1'b1, i_type_inst(12'h000, 3'b001, 7'h33), 64'h0, 1'b1, 6'd62, 6'd1, 6'd2);
    issue_inst(1'b1, i_type_inst(12'h000, 3'b000, 7'h63), 64'h0, 1'b1, 6'd63, 6'd1, 6'd2);
    issue_inst(1'b0, r_type_inst(7'h00, 7'h33), 64'h0, 1'b1, 6'd60, 6'd1, 6'd2);
    wait_cycles(3);
    issue_inst(1'b1, r_type_inst(7'h00, 7'h33), 64'h0, 1'b1, 6'd58, 6'd60, 6'd60);
    report_test("completion_rules", err_start);
  endtask

  initial begin
    for (int r = 0; r < `PHY_REGS; r++) shadow[r] = '0;
    i_issue = '0;
    i_issue_index_oh = '0;
    i_ext_phy_wr = '0;
    i_reset_n = 1'b1;
    #1 i_reset_n = 1'b0;
    repeat (3) @(posedge i_clk);
    #2 i_reset_n = 1'b1;
    register_ops();
    upper_imm_ops();
    word_ops();
    dependency_chains();
    ext_forwarding();
    completion_rules();
    $display("%0d tests run, %0d with errors, %0d errors in total", n_tests, n_failed, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* tb/alu_exec_assertions.sv */
module alu_exec_assertions
  import alu_exec_pkg::*;
(
  input logic      i_clk,
  input logic      i_reset_n,
  input early_wr_t o_early_wr,
  input phy_wr_t   o_phy_wr,
  input done_t     o_done
);

  timeunit 1ns;
  timeprecision 1ps;

  done_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done.valid |-> $onehot(o_done.index_oh))
    else $error("done index is not one-hot");

  wb_has_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_phy_wr.valid |-> o_done.valid)
    else $error("write-back without completion");

  // Wakeup leads the result by two cycles.
  early_then_wb: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_early_wr.valid |-> ##2 o_phy_wr.valid)
    else $error("early wakeup not followed by write-back");

  quiet_in_reset: assert property (@(posedge i_clk)
    !i_reset_n |-> !(o_early_wr.valid || o_phy_wr.valid || o_done.valid))
    else $error("valid output during reset");

endmodule

bind alu_exec_top alu_exec_assertions alu_exec_assertions_inst (
  .i_clk      (i_clk),
  .i_reset_n  (i_reset_n),
  .o_early_wr (o_early_wr),
  .o_phy_wr   (o_phy_wr),
  .o_done     (o_done)
);

/* source/alu_exec_top.sv */
`include "alu_exec_params.svh"

module alu_exec_top
  import alu_exec_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  issue_t                    i_issue,
  input  logic [`RV_ENTRY_SIZE-1:0] i_issue_index_oh,
  input  phy_wr_t                   i_ext_phy_wr,
  output early_wr_t                 o_early_wr,
  output phy_wr_t                   o_phy_wr,
  output done_t                     o_done
);

  regread_t         w_rd_rs1;
  regread_t         w_rd_rs2;
  logic [`XLEN-1:0] w_rs1_data;
  logic [`XLEN-1:0] w_rs2_data;
  phy_wr_t          w_ex3_phy_wr;
  phy_wr_t          w_phy_wr_bus [`TGT_BUS_SIZE];

  assign w_phy_wr_bus[0] = w_ex3_phy_wr; // Own result.
  assign w_phy_wr_bus[1] = i_ext_phy_wr; // External producer.
  assign o_phy_wr        = w_ex3_phy_wr;

  alu_pipe alu_pipe_inst (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_issue      (i_issue),
    .i_index_oh   (i_issue_index_oh),
    .i_phy_wr     (w_phy_wr_bus),
    .o_rd_rs1     (w_rd_rs1),
    .o_rd_rs2     (w_rd_rs2),
    .i_rs1_data   (w_rs1_data),
    .i_rs2_data   (w_rs2_data),
    .o_early_wr   (o_early_wr),
    .o_ex3_phy_wr (w_ex3_phy_wr),
    .o_done       (o_done)
  );

  phy_regfile phy_regfile_inst (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_rd_rs1   (w_rd_rs1),
    .i_rd_rs2   (w_rd_rs2),
    .o_rs1_data (w_rs1_data),
    .o_rs2_data (w_rs2_data),
    .i_phy_wr   (w_phy_wr_bus)
  );

endmodule

/* source/alu_pipe.sv */
`include "alu_exec_params.svh"

module alu_pipe
  import alu_exec_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  issue_t                    i_issue,
  input  logic [`RV_ENTRY_SIZE-1:0] i_index_oh,
  input  phy_wr_t                   i_phy_wr [`TGT_BUS_SIZE],
  output regread_t                  o_rd_rs1,
  output regread_t                  o_rd_rs2,
  input  logic [`XLEN-1:0]          i_rs1_data,
  input  logic [`XLEN-1:0]          i_rs2_data,
  output early_wr_t                 o_early_wr,
  output phy_wr_t                   o_ex3_phy_wr,
  output done_t                     o_done
);

  typedef struct packed {
    alu_op_e op;
    logic    imm;
  } pipe_ctrl_t;

  alu_op_e                   w_ex0_op;
  logic                      w_ex0_imm;
  pipe_ctrl_t                w_ex0_ctrl;

  issue_t                    r_ex1_issue;
  logic [`RV_ENTRY_SIZE-1:0] r_ex1_index;
  pipe_ctrl_t                r_ex1_ctrl;

  issue_t                    r_ex2_issue;
  logic [`RV_ENTRY_SIZE-1:0] r_ex2_index;
  pipe_ctrl_t                r_ex2_ctrl;
  logic [`XLEN-1:0]          r_ex2_rs1_data;
  logic [`XLEN-1:0]          r_ex2_rs2_data;
  logic [`XLEN-1:0]          w_ex2_rs1_op;
  logic [`XLEN-1:0]          w_ex2_rs2_op;
  logic [`XLEN-1:0]          w_ex2_uimm;
  logic [31:0]               w_ex2_sum32;
  logic [`XLEN-1:0]          w_ex2_result;

  issue_t                    r_ex3_issue;
  logic [`RV_ENTRY_SIZE-1:0] r_ex3_index;
  logic [`XLEN-1:0]          r_ex3_result;

  alu_ctrl_decoder alu_ctrl_decoder_inst (
    .i_inst (i_issue.inst),
    .o_op   (w_ex0_op),
    .o_imm  (w_ex0_imm)
  );

  assign w_ex0_ctrl = '{op: w_ex0_op, imm: w_ex0_imm};

  // Stage control, cleared on reset.
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
      r_ex1_index <= '0;
      r_ex1_ctrl  <= '0;
      r_ex2_issue <= '0;
      r_ex2_index <= '0;
      r_ex2_ctrl  <= '0;
      r_ex3_issue <= '0;
      r_ex3_index <= '0;
    end else begin
      r_ex1_issue <= i_issue;
      r_ex1_index <= i_index_oh;
      r_ex1_ctrl  <= w_ex0_ctrl;
      r_ex2_issue <= r_ex1_issue;
      r_ex2_index <= r_ex1_index;
      r_ex2_ctrl  <= r_ex1_ctrl;
      r_ex3_issue <= r_ex2_issue;
      r_ex3_index <= r_ex2_index;
    end
  end

  assign o_rd_rs1.valid = r_ex1_issue.valid & r_ex1_issue.rs1_valid;
  assign o_rd_rs1.rnid  = r_ex1_issue.rs1_rnid;
  assign o_rd_rs2.valid = r_ex1_issue.valid & r_ex1_issue.rs2_valid;
  assign o_rd_rs2.rnid  = r_ex1_issue.rs2_rnid;

  assign o_early_wr.valid   = r_ex1_issue.valid & r_ex1_issue.rd_valid;
  assign o_early_wr.rd_type = r_ex1_issue.rd_type;
  assign o_early_wr.rd_rnid = r_ex1_issue.rd_rnid;

  // Operand data.
  always_ff @(posedge i_clk) begin
    r_ex2_rs1_data <= i_rs1_data;
    r_ex2_rs2_data <= r_ex1_ctrl.imm ?
                      {{(`XLEN-12){r_ex1_issue.inst[31]}}, r_ex1_issue.inst[31:20]} :
                      i_rs2_data;
  end

  // Bus hit overrides the EX1 read, highest target last.
  always_comb begin
    w_ex2_rs1_op = r_ex2_rs1_data;
    w_ex2_rs2_op = r_ex2_rs2_data;
    for (int i = 0; i < `TGT_BUS_SIZE; i++) begin
      if (i_phy_wr[i].valid && r_ex2_issue.rs1_valid &&
          (i_phy_wr[i].rd_type == r_ex2_issue.rs1_type) &&
          (i_phy_wr[i].rd_rnid == r_ex2_issue.rs1_rnid)) begin
        w_ex2_rs1_op = i_phy_wr[i].rd_data;
      end
      if (i_phy_wr[i].valid && r_ex2_issue.rs2_valid && !r_ex2_ctrl.imm &&
          (i_phy_wr[i].rd_type == r_ex2_issue.rs2_type) &&
          (i_phy_wr[i].rd_rnid == r_ex2_issue.rs2_rnid)) begin
        w_ex2_rs2_op = i_phy_wr[i].rd_data;
      end
    end
  end

  assign w_ex2_uimm  = {{(`XLEN-32){r_ex2_issue.inst[31]}}, r_ex2_issue.inst[31:12], 12'h000};
  assign w_ex2_sum32 = w_ex2_rs1_op[31:0] + w_ex2_rs2_op[31:0];

  always_comb begin
    case (r_ex2_ctrl.op)
      OP_LUI:    w_ex2_result = w_ex2_uimm;
      OP_AUIPC:  w_ex2_result = r_ex2_issue.pc_addr + w_ex2_uimm;
      OP_ADD:    w_ex2_result = w_ex2_rs1_op + w_ex2_rs2_op;
      OP_SUB:    w_ex2_result = w_ex2_rs1_op - w_ex2_rs2_op;
      OP_ADD_32: w_ex2_result = {{(`XLEN-32){w_ex2_sum32[31]}}, w_ex2_sum32};
      default:   w_ex2_result = '0; // Unsupported encodings.
    endcase
  end

  always_ff @(posedge i_clk) begin
    r_ex3_result <= w_ex2_result;
  end

  assign o_ex3_phy_wr.valid   = r_ex3_issue.valid & r_ex3_issue.rd_valid;
  assign o_ex3_phy_wr.rd_type = r_ex3_issue.rd_type;
  assign o_ex3_phy_wr.rd_rnid = r_ex3_issue.rd_rnid;
  assign o_ex3_phy_wr.rd_data = r_ex3_result;

  assign o_done.valid    = r_ex3_issue.valid;
  assign o_done.index_oh = r_ex3_index;

endmodule

/* source/phy_regfile.sv */
`include "alu_exec_params.svh"

module phy_regfile
  import alu_exec_pkg::*;
(
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  regread_t         i_rd_rs1,
  input  regread_t         i_rd_rs2,
  output logic [`XLEN-1:0] o_rs1_data,
  output logic [`XLEN-1:0] o_rs2_data,
  input  phy_wr_t          i_phy_wr [`TGT_BUS_SIZE]
);

  logic [`XLEN-1:0]        r_regs [`PHY_REGS];
  logic [`TGT_BUS_SIZE-1:0] w_wr_gpr;

  // Only GPR targets land here.
  always_comb begin
    for (int i = 0; i < `TGT_BUS_SIZE; i++) begin
      w_wr_gpr[i] = i_phy_wr[i].valid && (i_phy_wr[i].rd_type == GPR);
    end
  end

  // Later targets override earlier ones, same as the write order.
  function automatic logic [`XLEN-1:0] read_port(regread_t rd);
    logic [`XLEN-1:0] data;
    data = r_regs[rd.rnid];
    for (int i = 0; i < `TGT_BUS_SIZE; i++) begin
      if (w_wr_gpr[i] && (i_phy_wr[i].rd_rnid == rd.rnid)) begin
        data = i_phy_wr[i].rd_data; // Write-through.
      end
    end
    return rd.valid ? data : '0;
  endfunction

  always_comb begin
    o_rs1_data = read_port(i_rd_rs1);
    o_rs2_data = read_port(i_rd_rs2);
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < `PHY_REGS; r++) begin
        r_regs[r] <= '0;
      end
    end else begin
      for (int i = 0; i < `TGT_BUS_SIZE; i++) begin
        if (w_wr_gpr[i]) begin
          r_regs[i_phy_wr[i].rd_rnid] <= i_phy_wr[i].rd_data;
        end
      end
    end
  end

endmodule

/* source/alu_ctrl_decoder.sv */
`include "alu_exec_params.svh"

module alu_ctrl_decoder
  import alu_exec_pkg::*;
(
  input  logic [31:0] i_inst,
  output alu_op_e     o_op,
  output logic        o_imm
);

  typedef enum logic [6:0] {
    OPC_LUI       = 7'b0110111,
    OPC_AUIPC     = 7'b0010111,
    OPC_OP        = 7'b0110011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP_32     = 7'b0111011,
    OPC_OP_IMM_32 = 7'b0011011
  } opcode_e;

  logic [6:0] w_opcode;
  logic [2:0] w_funct3;
  logic [6:0] w_funct7;

  assign w_opcode = i_inst[6:0];
  assign w_funct3 = i_inst[14:12];
  assign w_funct7 = i_inst[31:25];

  always_comb begin
    o_op  = OP_NONE;
    o_imm = 1'b0;
    case (w_opcode)
      OPC_LUI:   o_op = OP_LUI;
      OPC_AUIPC: o_op = OP_AUIPC;
      OPC_OP: begin
        if (w_funct3 == 3'b000 && w_funct7 == 7'b0000000) begin
          o_op = OP_ADD;
        end else if (w_funct3 == 3'b000 && w_funct7 == 7'b0100000) begin
          o_op = OP_SUB;
        end
      end
      OPC_OP_IMM: begin
        if (w_funct3 == 3'b000) begin // ADDI.
          o_op  = OP_ADD;
          o_imm = 1'b1;
        end
      end
      OPC_OP_32: begin
        if (w_funct3 == 3'b000 && w_funct7 == 7'b0000000) begin
          o_op = OP_ADD_32;
        end
      end
      OPC_OP_IMM_32: begin
        if (w_funct3 == 3'b000) begin // ADDIW.
          o_op  = OP_ADD_32;
          o_imm = 1'b1;
        end
      end
      default: o_op = OP_NONE;
    endcase
  end

endmodule

/* source/alu_exec_pkg.sv */
`include "alu_exec_params.svh"

package alu_exec_pkg;

  typedef enum logic {
    GPR = 1'b0,
    FPR = 1'b1
  } reg_type_e;

  typedef enum logic [2:0] {
    OP_NONE   = 3'd0,
    OP_LUI    = 3'd1,
    OP_AUIPC  = 3'd2,
    OP_ADD    = 3'd3,
    OP_SUB    = 3'd4,
    OP_ADD_32 = 3'd5
  } alu_op_e;

  typedef struct packed {
    logic                valid;
    logic [31:0]         inst;
    logic [`XLEN-1:0]    pc_addr;
    logic                rd_valid;
    reg_type_e           rd_type;
    logic [`RNID_W-1:0]  rd_rnid;
    logic                rs1_valid;
    reg_type_e           rs1_type;
    logic [`RNID_W-1:0]  rs1_rnid;
    logic                rs2_valid;
    reg_type_e           rs2_type;
    logic [`RNID_W-1:0]  rs2_rnid;
  } issue_t;

  typedef struct packed {
    logic                valid;
    reg_type_e           rd_type;
    logic [`RNID_W-1:0]  rd_rnid;
    logic [`XLEN-1:0]    rd_data;
  } phy_wr_t;

  typedef struct packed {
    logic                valid;
    reg_type_e           rd_type;
    logic [`RNID_W-1:0]  rd_rnid;
  } early_wr_t;

  typedef struct packed {
    logic                valid;
    logic [`RNID_W-1:0]  rnid;
  } regread_t;

  typedef struct packed {
    logic                      valid;
    logic [`RV_ENTRY_SIZE-1:0] index_oh;
  } done_t;

endpackage

/* source/alu_exec_params.svh */
`ifndef ALU_EXEC_PARAMS_SVH
`define ALU_EXEC_PARAMS_SVH

// Data path width.
`define XLEN 64

// Physical register file depth.
`define PHY_REGS 64

// Rename id width, log2 of PHY_REGS.
`define RNID_W 6

// Reservation entries, one bit each in the completion index.
`define RV_ENTRY_SIZE 8

// Write-back targets. Target 0 is this slice, target 1 is external.
`define TGT_BUS_SIZE 2

`endif
